/* Makefile */
# Verilator flow for the csr unit testbench

TOP       ?= csr_unit_tb
SEED      ?= 32\'hc7951370
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator

FLIST := csr_unit.f
BIN   := $(OBJ_DIR)/V$(TOP)
SRCS  := $(wildcard verilog/*.sv test/*.sv test/*.svh)

.PHONY: compile run clean

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the log holds the pass line
run: compile
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* csr_unit.f */
+incdir+test
verilog/csr_isa_pkg.sv
verilog/csr_bus_pkg.sv
verilog/credit_queue.sv
verilog/csr_file.sv
verilog/trap_ctrl.sv
verilog/csr_unit_top.sv
test/csr_unit_tb.sv

/* test/csr_unit_model.svh */
`ifndef CSR_UNIT_MODEL_SVH
`define CSR_UNIT_MODEL_SVH

// shadow copy of the machine csr state
logic        sh_ie;
logic        sh_eie;
logic [31:0] sh_mepc;
logic        sh_irq;
logic [4:0]  sh_code;

task automatic model_reset();
    sh_ie   = 1'b0;
    sh_eie  = 1'b0;
    sh_mepc = '0;
    sh_irq  = 1'b0;
    sh_code = '0;
endtask

// architectural read view, hit low for an unimplemented address
function automatic logic [31:0] shadow_read(input logic [11:0] addr, output logic hit);
    logic [31:0] v;
    v   = '0;
    hit = 1'b1;
    case (addr)
        csr_isa_pkg::ADDR_MSTATUS:  v = {29'd0, csr_isa_pkg::MSTATUS_MODE, sh_ie};
        csr_isa_pkg::ADDR_MEPC:     v = sh_mepc;
        csr_isa_pkg::ADDR_MCAUSE:   v = {sh_irq, 26'd0, sh_code};
        csr_isa_pkg::ADDR_MCPUID:   v = csr_isa_pkg::MCPUID_VAL;
        csr_isa_pkg::ADDR_MIMPID:   v = csr_isa_pkg::MIMPID_VAL;
        csr_isa_pkg::ADDR_MESTATUS: v = {29'd0, csr_isa_pkg::MSTATUS_MODE, sh_eie};
        default:                    hit = 1'b0;
    endcase
    return v;
endfunction

// only ie survives in the status words, id registers ignore writes
function automatic void shadow_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
        csr_isa_pkg::ADDR_MSTATUS:  sh_ie = v[0];
        csr_isa_pkg::ADDR_MEPC:     sh_mepc = v;
        csr_isa_pkg::ADDR_MCAUSE: begin
            sh_irq  = v[31];
            sh_code = v[4:0];
        end
        csr_isa_pkg::ADDR_MESTATUS: sh_eie = v[0];
        default: ;
    endcase
endfunction

// expected response for one command, shadow state moves along
function automatic csr_bus_pkg::csr_rsp_t model_rsp(input csr_bus_pkg::csr_req_t r);
    csr_bus_pkg::csr_rsp_t rsp;
    logic [31:0]           old;
    logic                  hit;
    rsp.kind = r.kind;
    rsp.data = '0;
    rsp.err  = 1'b0;
    case (r.kind)
        csr_bus_pkg::CMD_CSR: begin
            old = shadow_read(r.addr, hit);
            if (!hit) begin
                rsp.err = 1'b1;
            end else begin
                rsp.data = old;
                case (r.op)
                    csr_isa_pkg::CSR_OP_WRITE: shadow_write(r.addr, r.wdata);
                    csr_isa_pkg::CSR_OP_SET:   shadow_write(r.addr, old | r.wdata);
                    csr_isa_pkg::CSR_OP_CLEAR: shadow_write(r.addr, old & ~r.wdata);
                    default: ;
                endcase
            end
        end
        // save pc and cause, stack ie then clear it
        csr_bus_pkg::CMD_TRAP: begin
            sh_mepc = r.pc;
            sh_irq  = r.cause[5];
            sh_code = r.cause[4:0];
            sh_eie  = sh_ie;
            sh_ie   = 1'b0;
        end
        csr_bus_pkg::CMD_RET: begin
            rsp.data = sh_mepc;
            sh_ie    = sh_eie;
        end
        default: ;
    endcase
    return rsp;
endfunction

`endif

/* test/csr_unit_tb.sv */
`timescale 1ns/10ps

module csr_unit_tb #(
    parameter logic [31:0] SEED = 32'hc7951370
);

    localparam int REQ_DEPTH   = 4;
    localparam int RSP_DEPTH   = 4;
    localparam int RSP_CREDITS = 2;
    // cycles any single wait may take
    localparam int TIMEOUT     = 200;

    logic                  clk;
    logic                  rst_i;
    logic                  req_valid_i;
    csr_bus_pkg::csr_req_t req_i;
    logic                  req_credit_o;
    logic                  rsp_valid_o;
    csr_bus_pkg::csr_rsp_t rsp_o;
    logic                  rsp_credit_i;

    `include "csr_unit_model.svh"

    // expected responses in request order
    csr_bus_pkg::csr_rsp_t exp_q [$];
    csr_bus_pkg::csr_rsp_t exp_rsp;
    int    req_cred;
    int    owed;
    int    rsp_count;
    int    checks;
    int    errors;
    int    checks_base;
    int    errors_base;
    logic  hold;
    string test_name;

    csr_unit_top #(
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_DEPTH   (RSP_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_credit_o (req_credit_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .rsp_credit_i (rsp_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // checking and helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst_i) begin
            if (req_credit_o) begin
                req_cred++;
                if (req_cred > REQ_DEPTH) begin
                    errors++;
                    $display("ERROR: more request credits returned than were spent");
                end
            end
            if (rsp_valid_o) begin
                rsp_count++;
                owed++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR: response arrived with no command outstanding in %s",
                             test_name);
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_value(test_name, 64'(exp_rsp), 64'(rsp_o));
                end
            end
        end
    end

    // hand back one response credit per cycle unless withheld
    always @(posedge clk) begin
        #2;
        if (!hold && owed > 0) begin
            rsp_credit_i = 1'b1;
            owed--;
        end else begin
            rsp_credit_i = 1'b0;
        end
    end

    function automatic csr_bus_pkg::csr_req_t csr_req(input logic [11:0] addr,
                                                      input csr_isa_pkg::csr_op_e op,
                                                      input logic [31:0] wdata);
        csr_bus_pkg::csr_req_t r;
        r       = '0;
        r.kind  = csr_bus_pkg::CMD_CSR;
        r.addr  = addr;
        r.op    = op;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic csr_bus_pkg::csr_req_t trap_req(input logic [31:0] pc,
                                                       input logic [5:0] cause);
        csr_bus_pkg::csr_req_t r;
        r       = '0;
        r.kind  = csr_bus_pkg::CMD_TRAP;
        r.pc    = pc;
        r.cause = cause;
        return r;
    endfunction

    function automatic csr_bus_pkg::csr_req_t ret_req();
        csr_bus_pkg::csr_req_t r;
        r      = '0;
        r.kind = csr_bus_pkg::CMD_RET;
        return r;
    endfunction

    function automatic csr_isa_pkg::csr_op_e random_op();
        return csr_isa_pkg::csr_op_e'(2'($urandom_range(1, 3)));
    endfunction

    // implemented registers plus two holes in the map
    function automatic logic [11:0] pool_addr(input int unsigned idx);
        case (idx)
            0:       return csr_isa_pkg::ADDR_MSTATUS;
            1:       return csr_isa_pkg::ADDR_MEPC;
            2:       return csr_isa_pkg::ADDR_MCAUSE;
            3:       return csr_isa_pkg::ADDR_MESTATUS;
            4:       return csr_isa_pkg::ADDR_MCPUID;
            5:       return csr_isa_pkg::ADDR_MIMPID;
            6:       return 12'h305;
            default: return 12'hB00;
        endcase
    endfunction

    // steps whole cycles until a request credit is held
    task automatic wait_credit(input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (req_cred == 0) begin
            if (n == limit) begin
                ok = 1'b0;
                break;
            end
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic send_cmd(input csr_bus_pkg::csr_req_t r);
        bit ok;
        wait_credit(TIMEOUT, ok);
        if (!ok) begin
            abort_run({"no request credit came back in ", test_name});
        end
        exp_q.push_back(model_rsp(r));
        req_cred--;
        req_valid_i = 1'b1;
        req_i       = r;
        @(posedge clk);
        #2;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == TIMEOUT) begin
                abort_run({"responses still missing at the end of ", test_name});
            end
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        checks_base = checks;
        errors_base = errors;
    endtask

    task automatic end_test();
        wait_drain();
        $display("test %s done: %0d checks, %0d errors", test_name,
                 checks - checks_base, errors - errors_base);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequences
    ////////////////////////////////////////////////////////////

    // old value returned, later read shows the field masks
    task automatic rmw_sequence();
        start_test("rmw");
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 8; j++) begin
                send_cmd(csr_req(pool_addr(i), random_op(), $urandom));
            end
            send_cmd(csr_req(pool_addr(i), csr_isa_pkg::CSR_OP_WRITE, 32'hFFFF_FFFF));
            send_cmd(csr_req(pool_addr(i), csr_isa_pkg::CSR_OP_NONE, '0));
        end
        end_test();
    endtask

    task automatic const_error_sequence();
        start_test("const_err");
        send_cmd(csr_req(csr_isa_pkg::ADDR_MCPUID, csr_isa_pkg::CSR_OP_WRITE, 32'hFFFF_FFFF));
        send_cmd(csr_req(csr_isa_pkg::ADDR_MCPUID, csr_isa_pkg::CSR_OP_NONE, '0));
        send_cmd(csr_req(csr_isa_pkg::ADDR_MIMPID, csr_isa_pkg::CSR_OP_CLEAR, 32'hFFFF_FFFF));
        send_cmd(csr_req(csr_isa_pkg::ADDR_MIMPID, csr_isa_pkg::CSR_OP_NONE, '0));
        // holes in the map, then confirm nothing moved
        send_cmd(csr_req(12'h305, csr_isa_pkg::CSR_OP_WRITE, $urandom));
        send_cmd(csr_req(12'hB00, csr_isa_pkg::CSR_OP_SET, $urandom));
        send_cmd(csr_req(12'h7C1, csr_isa_pkg::CSR_OP_CLEAR, $urandom));
        for (int i = 0; i < 4; i++) begin
            send_cmd(csr_req(pool_addr(i), csr_isa_pkg::CSR_OP_NONE, '0));
        end
        end_test();
    endtask

    task automatic trap_return_sequence();
        logic [31:0] pc;
        start_test("trap_ret");
        pc = $urandom & 32'hFFFF_FFFC;
        send_cmd(csr_req(csr_isa_pkg::ADDR_MSTATUS, csr_isa_pkg::CSR_OP_WRITE, 32'h1));
        send_cmd(trap_req(pc, 6'($urandom)));
        for (int i = 0; i < 4; i++) begin
            send_cmd(csr_req(pool_addr(i), csr_isa_pkg::CSR_OP_NONE, '0));
        end
        send_cmd(ret_req());
        send_cmd(csr_req(csr_isa_pkg::ADDR_MSTATUS, csr_isa_pkg::CSR_OP_NONE, '0));
        end_test();
    endtask

    task automatic random_mix();
        int          base;
        int unsigned k;
        start_test("mix");
        base = rsp_count;
        for (int i = 0; i < 200; i++) begin
            k = $urandom_range(0, 9);
            if (k == 8) begin
                send_cmd(trap_req($urandom & 32'hFFFF_FFFC, 6'($urandom)));
            end else if (k == 9) begin
                send_cmd(ret_req());
            end else begin
                send_cmd(csr_req(pool_addr(k), csr_isa_pkg::csr_op_e'(2'($urandom)),
                                 $urandom));
            end
        end
        wait_drain();
        check_value("mix count", 64'(200), 64'(rsp_count - base));
        end_test();
    endtask

    // queues fill, then the credit return stops
    task automatic backpressure_sequence();
        int base;
        int sent;
        bit ok;
        start_test("backpress");
        @(negedge clk);
        hold = 1'b1;
        @(posedge clk);
        #2;
        base = rsp_count;
        sent = 0;
        for (int i = 0; i < 32; i++) begin
            wait_credit(20, ok);
            if (!ok) begin
                break;
            end
            send_cmd(csr_req(csr_isa_pkg::ADDR_MEPC, csr_isa_pkg::CSR_OP_WRITE, $urandom));
            sent++;
        end
        check_value("backpress held", 64'(1), 64'(rsp_count - base <= RSP_CREDITS));
        // outer credits, response queue, executor, request queue
        check_value("backpress absorbed", 64'(RSP_CREDITS + RSP_DEPTH + 1 + REQ_DEPTH),
                    64'(sent));
        @(negedge clk);
        hold = 1'b0;
        @(posedge clk);
        #2;
        wait_drain();
        check_value("backpress count", 64'(sent), 64'(rsp_count - base));
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        rsp_credit_i = 1'b0;
        hold         = 1'b0;
        req_cred     = REQ_DEPTH;
        owed         = 0;
        rsp_count    = 0;
        checks       = 0;
        errors       = 0;
        test_name    = "reset";
        model_reset();
        repeat (2) @(posedge clk);
        #2;
        rst_i = 1'b0;

        rmw_sequence();
        const_error_sequence();
        trap_return_sequence();
        random_mix();
        backpressure_sequence();

        $display("summary: %0d checks, %0d errors, %0d responses", checks, errors, rsp_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/credit_queue.sv */
`timescale 1ns/10ps

module credit_queue #(
    parameter type payload_t   = logic [7:0],
    parameter int  DEPTH       = 4,
    parameter int  OUT_CREDITS = 1
) (
    input  logic     clk,
    input  logic     rst_i,
    // write side, sender holds DEPTH credits after reset
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_credit_o,
    // read side, limited by credits from downstream
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_credit_i
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [CRED_W-1:0] cred_q;
    logic              send;

    // circular wrap
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // head leaves when present and a credit is held
    assign send        = (count_q != '0) && (cred_q != '0);
    assign out_valid_o = send;
    assign out_data_o  = mem[rd_ptr_q];
    // freed slot goes straight back upstream
    assign in_credit_o = send;

    // payload storage
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            cred_q   <= CRED_W'(OUT_CREDITS);
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (send) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // occupancy and output credits
            count_q <= count_q + CNT_W'(in_valid_i) - CNT_W'(send);
            cred_q  <= cred_q + CRED_W'(out_credit_i) - CRED_W'(send);
        end
    end

endmodule

/* verilog/csr_bus_pkg.sv */
package csr_bus_pkg;

    ////////////////////////////////////////////////////////////
    // command kinds
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CMD_CSR  = 2'd0,
        CMD_TRAP = 2'd1,
        CMD_RET  = 2'd2
    } cmd_kind_e;

    ////////////////////////////////////////////////////////////
    // request and response payloads
    ////////////////////////////////////////////////////////////

    // upstream command, 86 bits
    typedef struct packed {
        cmd_kind_e                                kind;
        logic [csr_isa_pkg::CSR_ADDR_W-1:0]       addr;
        csr_isa_pkg::csr_op_e                     op;
        logic [csr_isa_pkg::XLEN-1:0]             wdata;
        // faulting pc for a trap
        logic [csr_isa_pkg::XLEN-1:0]             pc;
        logic [csr_isa_pkg::CAUSE_W-1:0]          cause;
    } csr_req_t;

    // one response per command, 35 bits
    typedef struct packed {
        cmd_kind_e                                kind;
        // old csr value, return pc, or zero
        logic [csr_isa_pkg::XLEN-1:0]             data;
        logic                                     err;
    } csr_rsp_t;

endpackage

/* verilog/csr_file.sv */
`timescale 1ns/10ps

module csr_file (
    input  logic                                clk,
    input  logic                                rst_i,
    // csr access
    input  logic [csr_isa_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
    input  csr_isa_pkg::csr_op_e                csr_op_i,
    input  logic [csr_isa_pkg::XLEN-1:0]        wdata_i,
    output logic [csr_isa_pkg::XLEN-1:0]        rd_data_o,
    output logic                                hit_o,
    // trap entry and return
    input  logic                                save_exp_i,
    input  logic                                save_cause_i,
    input  logic [csr_isa_pkg::XLEN-1:0]        mepc_i,
    input  logic [csr_isa_pkg::CAUSE_W-1:0]     cause_i,
    input  logic                                restore_exp_i,
    output logic [csr_isa_pkg::XLEN-1:0]        mepc_o
);

    localparam int XLEN    = csr_isa_pkg::XLEN;
    localparam int CAUSE_W = csr_isa_pkg::CAUSE_W;

    logic               mstatus_ie_q, mstatus_ie_n;
    logic               mestatus_ie_q, mestatus_ie_n;
    logic [XLEN-1:0]    mepc_q, mepc_n;
    logic [CAUSE_W-1:0] mcause_q, mcause_n;
    logic [XLEN-1:0]    wr_data;
    logic               wr_en;

    ////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_data_o = '0;
        hit_o     = 1'b1;
        case (csr_addr_i)
            // mode field above ie
            csr_isa_pkg::ADDR_MSTATUS:
                rd_data_o = {{(XLEN-3){1'b0}}, csr_isa_pkg::MSTATUS_MODE, mstatus_ie_q};
            csr_isa_pkg::ADDR_MEPC:     rd_data_o = mepc_q;
            // interrupt flag at bit 31
            csr_isa_pkg::ADDR_MCAUSE:
                rd_data_o = {mcause_q[CAUSE_W-1], {(XLEN-CAUSE_W){1'b0}},
                             mcause_q[CAUSE_W-2:0]};
            csr_isa_pkg::ADDR_MCPUID:   rd_data_o = csr_isa_pkg::MCPUID_VAL;
            csr_isa_pkg::ADDR_MIMPID:   rd_data_o = csr_isa_pkg::MIMPID_VAL;
            csr_isa_pkg::ADDR_MESTATUS:
                rd_data_o = {{(XLEN-3){1'b0}}, csr_isa_pkg::MSTATUS_MODE, mestatus_ie_q};
            // unimplemented
            default:                    hit_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // read-modify-write
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_op_i)
            csr_isa_pkg::CSR_OP_SET:   wr_data = wdata_i | rd_data_o;
            csr_isa_pkg::CSR_OP_CLEAR: wr_data = ~wdata_i & rd_data_o;
            default:                   wr_data = wdata_i;
        endcase
        wr_en = (csr_op_i != csr_isa_pkg::CSR_OP_NONE) && hit_o;
    end

    // trap strobes applied last so they win
    always_comb begin
        mstatus_ie_n  = mstatus_ie_q;
        mestatus_ie_n = mestatus_ie_q;
        mepc_n        = mepc_q;
        mcause_n      = mcause_q;
        if (wr_en) begin
            // constant ids fall through untouched
            case (csr_addr_i)
                csr_isa_pkg::ADDR_MSTATUS:  mstatus_ie_n  = wr_data[0];
                csr_isa_pkg::ADDR_MEPC:     mepc_n        = wr_data;
                csr_isa_pkg::ADDR_MCAUSE:   mcause_n      = {wr_data[XLEN-1], wr_data[4:0]};
                csr_isa_pkg::ADDR_MESTATUS: mestatus_ie_n = wr_data[0];
                default: ;
            endcase
        end
        if (save_cause_i) begin
            mcause_n = cause_i;
        end
        // stack ie and disable
        if (save_exp_i) begin
            mepc_n        = mepc_i;
            mestatus_ie_n = mstatus_ie_q;
            mstatus_ie_n  = 1'b0;
        end
        if (restore_exp_i) begin
            mstatus_ie_n = mestatus_ie_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mstatus_ie_q  <= 1'b0;
            mestatus_ie_q <= 1'b0;
            mepc_q        <= '0;
            mcause_q      <= '0;
        end else begin
            mstatus_ie_q  <= mstatus_ie_n;
            mestatus_ie_q <= mestatus_ie_n;
            mepc_q        <= mepc_n;
            mcause_q      <= mcause_n;
        end
    end

    assign mepc_o = mepc_q;

endmodule

/* verilog/csr_isa_pkg.sv */
package csr_isa_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    // top bit flags an interrupt, low five bits hold the code
    localparam int CAUSE_W    = 6;

    // csr access kinds
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    ////////////////////////////////////////////////////////////
    // machine csr map
    ////////////////////////////////////////////////////////////

    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCPUID   = 12'hF00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID   = 12'hF01;
    // non-standard stacked status
    localparam logic [CSR_ADDR_W-1:0] ADDR_MESTATUS = 12'h7C0;

    // rv32i base
    localparam logic [XLEN-1:0] MCPUID_VAL = 32'h0000_0100;
    // no allocated implementation id
    localparam logic [XLEN-1:0] MIMPID_VAL = 32'h0000_8000;

    // always machine mode
    localparam logic [1:0] MSTATUS_MODE = 2'b11;

endpackage

/* verilog/csr_unit_top.sv */
`timescale 1ns/10ps

module csr_unit_top #(
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_i,
    // inbound commands
    input  logic                  req_valid_i,
    input  csr_bus_pkg::csr_req_t req_i,
    output logic                  req_credit_o,
    // outbound responses
    output logic                  rsp_valid_o,
    output csr_bus_pkg::csr_rsp_t rsp_o,
    input  logic                  rsp_credit_i
);

    ////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////

    // request queue to executor
    logic                                cmd_valid;
    csr_bus_pkg::csr_req_t               cmd;
    logic                                cmd_credit;
    // executor to response queue
    logic                                push_valid;
    csr_bus_pkg::csr_rsp_t               push_rsp;
    logic                                push_credit;
    // executor to csr file
    logic [csr_isa_pkg::CSR_ADDR_W-1:0]  csr_addr;
    csr_isa_pkg::csr_op_e                csr_op;
    logic [csr_isa_pkg::XLEN-1:0]        csr_wdata;
    logic                                save_exp;
    logic                                save_cause;
    logic [csr_isa_pkg::XLEN-1:0]        trap_pc;
    logic [csr_isa_pkg::CAUSE_W-1:0]     trap_cause;
    logic                                restore_exp;
    logic [csr_isa_pkg::XLEN-1:0]        csr_rd_data;
    logic                                csr_hit;
    logic [csr_isa_pkg::XLEN-1:0]        mepc;

    // single output credit keeps one command in the executor
    credit_queue #(
        .payload_t   (csr_bus_pkg::csr_req_t),
        .DEPTH       (REQ_DEPTH),
        .OUT_CREDITS (1)
    ) u_req_q (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (req_valid_i),
        .in_data_i    (req_i),
        .in_credit_o  (req_credit_o),
        .out_valid_o  (cmd_valid),
        .out_data_o   (cmd),
        .out_credit_i (cmd_credit)
    );

    trap_ctrl #(
        .RSP_DEPTH (RSP_DEPTH)
    ) u_trap (
        .clk           (clk),
        .rst_i         (rst_i),
        .cmd_valid_i   (cmd_valid),
        .cmd_i         (cmd),
        .cmd_credit_o  (cmd_credit),
        .rsp_valid_o   (push_valid),
        .rsp_o         (push_rsp),
        .rsp_credit_i  (push_credit),
        .csr_addr_o    (csr_addr),
        .csr_op_o      (csr_op),
        .wdata_o       (csr_wdata),
        .save_exp_o    (save_exp),
        .save_cause_o  (save_cause),
        .mepc_o        (trap_pc),
        .cause_o       (trap_cause),
        .restore_exp_o (restore_exp),
        .rd_data_i     (csr_rd_data),
        .hit_i         (csr_hit),
        .mepc_i        (mepc)
    );

    csr_file u_csr (
        .clk           (clk),
        .rst_i         (rst_i),
        .csr_addr_i    (csr_addr),
        .csr_op_i      (csr_op),
        .wdata_i       (csr_wdata),
        .rd_data_o     (csr_rd_data),
        .hit_o         (csr_hit),
        .save_exp_i    (save_exp),
        .save_cause_i  (save_cause),
        .mepc_i        (trap_pc),
        .cause_i       (trap_cause),
        .restore_exp_i (restore_exp),
        .mepc_o        (mepc)
    );

    // outside grants RSP_CREDITS for responses
    credit_queue #(
        .payload_t   (csr_bus_pkg::csr_rsp_t),
        .DEPTH       (RSP_DEPTH),
        .OUT_CREDITS (RSP_CREDITS)
    ) u_rsp_q (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (push_valid),
        .in_data_i    (push_rsp),
        .in_credit_o  (push_credit),
        .out_valid_o  (rsp_valid_o),
        .out_data_o   (rsp_o),
        .out_credit_i (rsp_credit_i)
    );

endmodule

/* verilog/trap_ctrl.sv */
`timescale 1ns/10ps

module trap_ctrl #(
    parameter int RSP_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_i,
    // from request queue
    input  logic                                cmd_valid_i,
    input  csr_bus_pkg::csr_req_t               cmd_i,
    output logic                                cmd_credit_o,
    // to response queue
    output logic                                rsp_valid_o,
    output csr_bus_pkg::csr_rsp_t               rsp_o,
    input  logic                                rsp_credit_i,
    // csr file control
    output logic [csr_isa_pkg::CSR_ADDR_W-1:0]  csr_addr_o,
    output csr_isa_pkg::csr_op_e                csr_op_o,
    output logic [csr_isa_pkg::XLEN-1:0]        wdata_o,
    output logic                                save_exp_o,
    output logic                                save_cause_o,
    output logic [csr_isa_pkg::XLEN-1:0]        mepc_o,
    output logic [csr_isa_pkg::CAUSE_W-1:0]     cause_o,
    output logic                                restore_exp_o,
    input  logic [csr_isa_pkg::XLEN-1:0]        rd_data_i,
    input  logic                                hit_i,
    input  logic [csr_isa_pkg::XLEN-1:0]        mepc_i
);

    localparam int CRED_W = $clog2(RSP_DEPTH + 1);

    csr_bus_pkg::csr_req_t cmd_q;
    logic                  busy_q;
    logic [CRED_W-1:0]     rsp_cred_q;
    logic                  take;
    logic                  fire;
    logic                  is_csr;

    // one command in flight, request queue only sends when we are empty
    assign take   = cmd_valid_i && !busy_q;
    // execute and push together, stall without response space
    assign fire   = busy_q && (rsp_cred_q != '0);
    assign is_csr = (cmd_q.kind == csr_bus_pkg::CMD_CSR);

    ////////////////////////////////////////////////////////////
    // csr side effects, only in the push cycle
    ////////////////////////////////////////////////////////////

    assign csr_addr_o    = cmd_q.addr;
    assign wdata_o       = cmd_q.wdata;
    assign mepc_o        = cmd_q.pc;
    assign cause_o       = cmd_q.cause;
    // miss turns the access into a pure read
    assign csr_op_o      = (fire && is_csr && hit_i) ? cmd_q.op : csr_isa_pkg::CSR_OP_NONE;
    assign save_exp_o    = fire && (cmd_q.kind == csr_bus_pkg::CMD_TRAP);
    assign save_cause_o  = fire && (cmd_q.kind == csr_bus_pkg::CMD_TRAP);
    assign restore_exp_o = fire && (cmd_q.kind == csr_bus_pkg::CMD_RET);

    // response build
    always_comb begin
        rsp_o.kind = cmd_q.kind;
        rsp_o.data = '0;
        rsp_o.err  = 1'b0;
        case (cmd_q.kind)
            // old value, sampled before the write lands
            csr_bus_pkg::CMD_CSR: begin
                rsp_o.data = hit_i ? rd_data_i : '0;
                rsp_o.err  = !hit_i;
            end
            csr_bus_pkg::CMD_RET:  rsp_o.data = mepc_i;
            default:               rsp_o.data = '0;
        endcase
    end

    assign rsp_valid_o  = fire;
    // stage empties, return the upstream credit
    assign cmd_credit_o = fire;

    // command register
    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q <= cmd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            rsp_cred_q <= CRED_W'(RSP_DEPTH);
        end else begin
            if (take) begin
                busy_q <= 1'b1;
            end else if (fire) begin
                busy_q <= 1'b0;
            end
            rsp_cred_q <= rsp_cred_q + CRED_W'(rsp_credit_i) - CRED_W'(fire);
        end
    end

endmodule
